/* files.f */
+incdir+verif
src/filterPkg.sv
src/coeffMapPkg.sv
src/coeffAccess.sv
src/tapSequencer.sv
src/coeffBank.sv
src/delayLine.sv
src/macLane.sv
src/bankCombiner.sv
src/firTop.sv
verif/tbFirTop.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the FIR filter testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tbFirTop -f files.f -Mdir obj_dir

output=$(./obj_dir/VtbFirTop)
echo "$output"

if grep -q "SIMULATION PASSED" <<< "$output"; then
  exit 0
fi
exit 1

/* src/bankCombiner.sv */
// Final bank sum
// Adds the lane results, saturates to 16 bits and registers the filter output
// with a one-cycle valid pulse
`timescale 1ns/1ps
`default_nettype none

module bankCombiner (
  input  logic            iClk,
  input  logic            arstN,
  input  filterPkg::laneT laneIn [coeffMapPkg::NumBanks],
  input  logic            sumEn,
  output filterPkg::laneT oFirOut,
  output logic            oFirValid
);
  import filterPkg::*;
  import coeffMapPkg::*;

  // Product, accumulate and lane registers between last tap and lane result
  localparam int LaneDelay = 3;

  logic [LaneDelay-1:0] lastPipe;
  sumT                  total;

  always_comb
  begin
    total = '0;
    for (int b = 0; b < NumBanks; b++)
      total = total + sumT'(laneIn[b]);
  end

  always_ff @(posedge iClk or negedge arstN)
  begin
    if (!arstN)
    begin
      lastPipe  <= '0;
      oFirOut   <= '0;
      oFirValid <= 1'b0;
    end
    else
    begin
      lastPipe  <= {lastPipe[LaneDelay-2:0], sumEn};
      oFirValid <= lastPipe[LaneDelay-1];
      if (lastPipe[LaneDelay-1])
        oFirOut <= satLane(accT'(total));
    end
  end

endmodule

`default_nettype wire

/* src/coeffAccess.sv */
// Coefficient bank access
// Registers external writes and steers the shared bank port between the
// writer and the sequencer's read path
`timescale 1ns/1ps
`default_nettype none

module coeffAccess (
  input  logic                                iClk,
  input  logic                                arstN,
  input  logic                                iCoeffUpdate,
  input  logic                                iCoeffWrEn,
  input  coeffMapPkg::coeffAddrU              iCoeffAddr,
  input  filterPkg::coeffT                    iCoeffData,
  input  logic                                rdEn,
  input  logic [filterPkg::TapIdxW-1:0]       rdIdx,
  output logic [coeffMapPkg::NumBanks-1:0]    bankCe,
  output logic [coeffMapPkg::NumBanks-1:0]    bankWe,
  output logic [filterPkg::TapIdxW-1:0]       bankAddr,
  output filterPkg::coeffT                    bankWrData
);
  import coeffMapPkg::*;

  logic      wrPend;
  coeffAddrU wrAddr;

  always_ff @(posedge iClk or negedge arstN)
  begin
    if (!arstN)
      wrPend <= 1'b0;
    else
      wrPend <= iCoeffUpdate && iCoeffWrEn;
  end

  // Write payload, committed to the bank one cycle later
  always_ff @(posedge iClk)
  begin
    if (iCoeffUpdate && iCoeffWrEn)
    begin
      wrAddr.flat <= iCoeffAddr.flat;
      bankWrData  <= iCoeffData;
    end
  end

  always_comb
  begin
    bankCe   = '0;
    bankWe   = '0;
    bankAddr = rdIdx;
    if (wrPend)
    begin
      // One bank selected by the upper address bits
      bankCe[wrAddr.field.bank] = 1'b1;
      bankWe                    = bankCe;
      bankAddr                  = wrAddr.field.index;
    end
    else
      bankCe = {NumBanks{rdEn}};
  end

endmodule

`default_nettype wire

/* src/coeffBank.sv */
// Coefficient bank
// Single-port memory with a registered read, one word per tap
`timescale 1ns/1ps
`default_nettype none

module coeffBank #(
  parameter int TapsPerBank = 10
) (
  input  logic                          iClk,
  input  logic                          ce,
  input  logic                          we,
  input  logic [filterPkg::TapIdxW-1:0] addr,
  input  filterPkg::coeffT              wrData,
  output filterPkg::coeffT              rdData
);
  import filterPkg::*;

  coeffT mem [TapsPerBank];

  always_ff @(posedge iClk)
  begin
    if (ce)
    begin
      if (we)
      begin
        // Indexes past the bank depth are dropped
        if (addr < TapsPerBank)
          mem[addr] <= wrData;
      end
      else
        rdData <= mem[addr];
    end
  end

endmodule

`default_nettype wire

/* src/coeffMapPkg.sv */
// Coefficient memory map
// Bank count and the 6-bit write address, seen flat or as bank plus index
`default_nettype none

package coeffMapPkg;

  // ====================
  // Memory map
  // ====================
  localparam int NumBanks   = 4;
  localparam int BankSelW   = 2;
  localparam int CoeffAddrW = 6;

  // Lower bits pick the coefficient inside a bank
  localparam int IdxW = CoeffAddrW - BankSelW;

  typedef struct packed {
    logic [BankSelW-1:0] bank;
    logic [IdxW-1:0]     index;
  } coeffFieldT;

  // Same address word, two views
  typedef union packed {
    logic [CoeffAddrW-1:0] flat;
    coeffFieldT            field;
  } coeffAddrU;

endpackage

`default_nettype wire

/* src/delayLine.sv */
// Sample delay segment
// Shifts a new sample in on shiftEn, reads one tap by select and passes the
// oldest tap on to the next segment
`timescale 1ns/1ps
`default_nettype none

module delayLine #(
  parameter int TapsPerBank = 10
) (
  input  logic                          iClk,
  input  logic                          arstN,
  input  logic                          shiftEn,
  input  filterPkg::sampleT             sampleIn,
  input  logic [filterPkg::TapIdxW-1:0] tapSel,
  output filterPkg::sampleT             tapOut,
  output filterPkg::sampleT             chainOut
);
  import filterPkg::*;

  // Tap 0 holds the newest sample
  sampleT taps [TapsPerBank];

  always_ff @(posedge iClk or negedge arstN)
  begin
    if (!arstN)
    begin
      for (int i = 0; i < TapsPerBank; i++)
        taps[i] <= '0;
    end
    else if (shiftEn)
    begin
      taps[0] <= sampleIn;
      for (int i = 1; i < TapsPerBank; i++)
        taps[i] <= taps[i-1];
    end
  end

  assign tapOut   = (tapSel < TapsPerBank) ? taps[tapSel] : '0;
  assign chainOut = taps[TapsPerBank-1];

endmodule

`default_nettype wire

/* src/filterPkg.sv */
// Filter arithmetic definitions
// Sample, coefficient, product and accumulator types plus the 16-bit clamp
`default_nettype none

package filterPkg;

  // ====================
  // Widths
  // ====================
  localparam int SampleW = 3;
  localparam int CoeffW  = 16;
  localparam int MulW    = CoeffW + SampleW;
  localparam int AccW    = 20;
  localparam int SumW    = 18;
  localparam int TapIdxW = 4;

  typedef logic signed [SampleW-1:0] sampleT;
  typedef logic signed [CoeffW-1:0]  coeffT;
  typedef logic signed [CoeffW-1:0]  productT;
  typedef logic signed [CoeffW-1:0]  laneT;
  typedef logic signed [AccW-1:0]    accT;
  typedef logic signed [SumW-1:0]    sumT;

  localparam laneT SatMax = 16'sh7FFF;
  localparam laneT SatMin = 16'sh8000;

  // Clamp any narrower signed value into the lane range
  function automatic laneT satLane(input accT value);
    laneT result;
    if (value > accT'(SatMax))
      result = SatMax;
    else if (value < accT'(SatMin))
      result = SatMin;
    else
      result = laneT'(value);
    return result;
  endfunction

endpackage

`default_nettype wire

/* src/firTop.sv */
// 40-tap FIR filter top level
// Four coefficient banks, four delay segments and four MAC lanes working in
// parallel, with a saturating final sum
`timescale 1ns/1ps
`default_nettype none

module firTop #(
  parameter int TapsPerBank = 10
) (
  input  logic                    iClk,
  input  logic                    arstN,
  input  logic                    iCoeffUpdate,
  input  logic                    iCoeffWrEn,
  input  coeffMapPkg::coeffAddrU  iCoeffAddr,
  input  filterPkg::coeffT        iCoeffData,
  input  logic                    iSampleEn,
  input  filterPkg::sampleT       iSample,
  output filterPkg::laneT         oFirOut,
  output logic                    oFirValid
);
  import filterPkg::*;
  import coeffMapPkg::*;

  logic [NumBanks-1:0] bankCe;
  logic [NumBanks-1:0] bankWe;
  logic [TapIdxW-1:0]  bankAddr;
  coeffT               bankWrData;
  coeffT               bankRd [NumBanks];

  logic               shiftEn;
  logic               rdEn;
  logic [TapIdxW-1:0] rdIdx;
  logic [TapIdxW-1:0] tapSel;
  logic               firstTap;
  logic               lastTap;

  // Segment b reads chain[b] and feeds chain[b+1]
  sampleT chain [NumBanks+1];
  sampleT tapOut [NumBanks];
  laneT   laneOut [NumBanks];

  assign chain[0] = iSample;

  coeffAccess uAccess (
    .iClk         (iClk),
    .arstN        (arstN),
    .iCoeffUpdate (iCoeffUpdate),
    .iCoeffWrEn   (iCoeffWrEn),
    .iCoeffAddr   (iCoeffAddr),
    .iCoeffData   (iCoeffData),
    .rdEn         (rdEn),
    .rdIdx        (rdIdx),
    .bankCe       (bankCe),
    .bankWe       (bankWe),
    .bankAddr     (bankAddr),
    .bankWrData   (bankWrData)
  );

  tapSequencer #(.TapsPerBank(TapsPerBank)) uSeq (
    .iClk         (iClk),
    .arstN        (arstN),
    .iCoeffUpdate (iCoeffUpdate),
    .iSampleEn    (iSampleEn),
    .shiftEn      (shiftEn),
    .rdEn         (rdEn),
    .rdIdx        (rdIdx),
    .tapSel       (tapSel),
    .firstTap     (firstTap),
    .lastTap      (lastTap)
  );

  // ====================
  // Per-bank lanes
  // ====================
  for (genvar b = 0; b < NumBanks; b++)
  begin : genLane
    coeffBank #(.TapsPerBank(TapsPerBank)) uBank (
      .iClk(iClk), .ce(bankCe[b]), .we(bankWe[b]), .addr(bankAddr),
      .wrData(bankWrData), .rdData(bankRd[b])
    );

    delayLine #(.TapsPerBank(TapsPerBank)) uDelay (
      .iClk(iClk), .arstN(arstN), .shiftEn(shiftEn), .sampleIn(chain[b]),
      .tapSel(tapSel), .tapOut(tapOut[b]), .chainOut(chain[b+1])
    );

    macLane uMac (
      .iClk(iClk), .arstN(arstN), .coeff(bankRd[b]), .tapIn(tapOut[b]),
      .firstTap(firstTap), .lastTap(lastTap), .laneOut(laneOut[b])
    );
  end

  bankCombiner uComb (
    .iClk      (iClk),
    .arstN     (arstN),
    .laneIn    (laneOut),
    .sumEn     (lastTap),
    .oFirOut   (oFirOut),
    .oFirValid (oFirValid)
  );

endmodule

`default_nettype wire

/* src/macLane.sv */
// Multiply-accumulate lane for one coefficient bank
// Saturating coefficient x sample product, wide accumulation over the bank,
// saturated lane result on the last tap
`timescale 1ns/1ps
`default_nettype none

module macLane (
  input  logic              iClk,
  input  logic              arstN,
  input  filterPkg::coeffT  coeff,
  input  filterPkg::sampleT tapIn,
  input  logic              firstTap,
  input  logic              lastTap,
  output filterPkg::laneT   laneOut
);
  import filterPkg::*;

  logic signed [MulW-1:0] mulRaw;
  productT                prodQ;
  logic                   prodFirst;
  logic                   prodLast;
  accT                    accQ;
  logic                   accLast;

  assign mulRaw = coeff * tapIn;

  // ====================
  // Product stage
  // ====================
  always_ff @(posedge iClk)
  begin
    prodQ <= satLane(accT'(mulRaw));
  end

  always_ff @(posedge iClk or negedge arstN)
  begin
    if (!arstN)
    begin
      prodFirst <= 1'b0;
      prodLast  <= 1'b0;
      accLast   <= 1'b0;
    end
    else
    begin
      prodFirst <= firstTap;
      prodLast  <= lastTap;
      accLast   <= prodLast;
    end
  end

  // ====================
  // Accumulate stage
  // ====================
  // Load on the first product so no clear cycle is needed
  always_ff @(posedge iClk)
  begin
    if (prodFirst)
      accQ <= accT'(prodQ);
    else
      accQ <= accQ + accT'(prodQ);
  end

  always_ff @(posedge iClk or negedge arstN)
  begin
    if (!arstN)
      laneOut <= '0;
    else if (accLast)
      laneOut <= satLane(accQ);
  end

endmodule

`default_nettype wire

/* src/tapSequencer.sv */
// Per-sample tap sequencer
// Idle/run control with a read counter; shifts the delay line on an accepted
// strobe, walks the bank index and lines up tap select and flags with bank data
`timescale 1ns/1ps
`default_nettype none

module tapSequencer #(
  parameter int TapsPerBank = 10
) (
  input  logic                          iClk,
  input  logic                          arstN,
  input  logic                          iCoeffUpdate,
  input  logic                          iSampleEn,
  output logic                          shiftEn,
  output logic                          rdEn,
  output logic [filterPkg::TapIdxW-1:0] rdIdx,
  output logic [filterPkg::TapIdxW-1:0] tapSel,
  output logic                          firstTap,
  output logic                          lastTap
);
  import filterPkg::*;

  // Read phase, then product, accumulate, lane and sum stages
  localparam int RunLen = TapsPerBank + 6;
  localparam int CntW   = $clog2(RunLen);

  logic            busy;
  logic [CntW-1:0] cnt;
  logic            rdGo;

  assign shiftEn = iSampleEn && !busy && !iCoeffUpdate;
  assign rdGo    = busy && !iCoeffUpdate && (cnt < CntW'(TapsPerBank));

  // ====================
  // Run control
  // ====================
  always_ff @(posedge iClk or negedge arstN)
  begin
    if (!arstN)
    begin
      busy <= 1'b0;
      cnt  <= '0;
    end
    else if (iCoeffUpdate)
      busy <= 1'b0;
    else if (shiftEn)
    begin
      busy <= 1'b1;
      cnt  <= '0;
    end
    else if (busy)
    begin
      cnt <= cnt + 1'b1;
      // Free again on the edge that registers the filter output
      if (cnt == CntW'(RunLen - 2))
        busy <= 1'b0;
    end
  end

  always_ff @(posedge iClk or negedge arstN)
  begin
    if (!arstN)
    begin
      rdEn  <= 1'b0;
      rdIdx <= '0;
    end
    else
    begin
      rdEn <= rdGo;
      if (rdGo)
        rdIdx <= TapIdxW'(cnt);
    end
  end

  // One cycle behind rdIdx to match the bank read latency.
  // An update seen after the last read no longer stops the result
  always_ff @(posedge iClk or negedge arstN)
  begin
    if (!arstN)
    begin
      tapSel   <= '0;
      firstTap <= 1'b0;
      lastTap  <= 1'b0;
    end
    else
    begin
      tapSel   <= rdIdx;
      firstTap <= rdEn && !iCoeffUpdate && (rdIdx == '0);
      lastTap  <= rdEn && !iCoeffUpdate && (rdIdx == TapIdxW'(TapsPerBank - 1));
    end
  end

endmodule

`default_nettype wire

/* verif/tbModel.svh */
// FIR testbench reference model
// LFSR random source, shadow copies of the coefficients and of the sample
// history, and the expected filter output built from them
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam logic [31:0] LfsrSeed = 32'he72cf433;

logic [31:0] lfsrState = LfsrSeed;
coeffT       coefModel [TotalTaps];
// Newest sample first
sampleT      histModel [TotalTaps];

// ====================
// Random source
// ====================
// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic lfsrBit();
  logic fb;
  fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
  lfsrState = {lfsrState[30:0], fb};
  return fb;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] randomBits(input int n);
  logic [31:0] value;
  int          i;
  value = '0;
  for (i = 0; i < n; i++)
    value = {value[30:0], lfsrBit()};
  return value;
endfunction

// ====================
// Reference filter
// ====================
function automatic laneT clampLane(input int value);
  laneT result;
  if (value > 32767)
    result = 16'sh7FFF;
  else if (value < -32768)
    result = 16'sh8000;
  else
    result = laneT'(value);
  return result;
endfunction

function automatic void clearHistory();
  int i;
  for (i = 0; i < TotalTaps; i++)
    histModel[i] = '0;
endfunction

function automatic void shiftHistory(input sampleT s);
  int i;
  for (i = TotalTaps - 1; i > 0; i--)
    histModel[i] = histModel[i-1];
  histModel[0] = s;
endfunction

// Tap 10b+k pairs with bank b, index k; clamp product, bank sum and total
function automatic laneT firExpected();
  int b;
  int k;
  int bankSum;
  int total;
  total = 0;
  for (b = 0; b < NumBanks; b++)
  begin
    bankSum = 0;
    for (k = 0; k < TapsPerBank; k++)
      bankSum += int'(clampLane(int'(coefModel[b*TapsPerBank + k])
                                * int'(histModel[b*TapsPerBank + k])));
    total += int'(clampLane(bankSum));
  end
  return clampLane(total);
endfunction

`endif

/* verif/tbFirTop.sv */
// FIR filter testbench
// Loads coefficients, drives sample strobes and checks every output pulse
// against the reference model, including update and early-strobe control
`timescale 1ns/1ps
`default_nettype none

module tbFirTop;
  import filterPkg::*;
  import coeffMapPkg::*;

  localparam int TapsPerBank = 10;
  localparam int TotalTaps   = NumBanks * TapsPerBank;
  localparam int ResetCycles = 8;
  localparam int RandomLen   = 48;
  localparam int SatLen      = 2 * TotalTaps;
  localparam int CtrlStrobes = 6;
  localparam int RewriteLen  = 24;
  localparam int NumStrobes  = TotalTaps + RandomLen + SatLen + CtrlStrobes + RewriteLen;
  // Four full loads and one bank rewrite, a few cycles around each
  localparam int LoadCycles  = 4 * TotalTaps + TapsPerBank + 5 * 4;
  localparam int IdleCycles  = 64;
  localparam int CycleLimit  = 2 * (16 * NumStrobes + LoadCycles + IdleCycles + ResetCycles);

  logic      iClk;
  logic      arstN;
  logic      iCoeffUpdate;
  logic      iCoeffWrEn;
  coeffAddrU iCoeffAddr;
  coeffT     iCoeffData;
  logic      iSampleEn;
  sampleT    iSample;
  laneT      oFirOut;
  logic      oFirValid;

  laneT expQ [$];
  int   dueQ [$];
  laneT expVal;
  int   dueCycle;
  laneT lastOut         = '0;
  int   errCount        = 0;
  int   checkCount      = 0;
  int   pulseCount      = 0;
  int   expectedPulses  = 0;
  int   cycleCount      = 0;
  int   testStartErrors = 0;

  `include "tbModel.svh"

  firTop #(.TapsPerBank(TapsPerBank)) DUT (
    .iClk         (iClk),
    .arstN        (arstN),
    .iCoeffUpdate (iCoeffUpdate),
    .iCoeffWrEn   (iCoeffWrEn),
    .iCoeffAddr   (iCoeffAddr),
    .iCoeffData   (iCoeffData),
    .iSampleEn    (iSampleEn),
    .iSample      (iSample),
    .oFirOut      (oFirOut),
    .oFirValid    (oFirValid)
  );

  initial
  begin
    iClk = 1'b0;
    forever #2 iClk = ~iClk;
  end

  always @(posedge iClk)
  begin
    cycleCount++;
    if (cycleCount >= CycleLimit)
    begin
      $display("Timeout: no finish within %0d cycles", CycleLimit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ====================
  // Output checks
  // ====================
  pulseOneCycle: assert property (@(posedge iClk) disable iff (!arstN)
                                  oFirValid |=> !oFirValid)
  else
  begin
    errCount++;
    $display("oFirValid stayed high for more than one cycle");
  end

  outputHeld: assert property (@(posedge iClk) disable iff (!arstN)
                               !$stable(oFirOut) |-> oFirValid)
  else
  begin
    errCount++;
    $display("oFirOut changed without a valid pulse");
  end

  always @(negedge iClk)
  begin
    if (arstN && oFirValid)
    begin
      pulseCount++;
      checkCount++;
      assert (expQ.size() > 0)
      else
      begin
        errCount++;
        $display("oFirValid pulsed with no accepted strobe pending");
      end
      if (expQ.size() > 0)
      begin
        expVal   = expQ.pop_front();
        dueCycle = dueQ.pop_front();
        assert (oFirOut == expVal)
        else
        begin
          errCount++;
          $display("MISMATCH oFirOut: expected %h, got %h at pulse %0d",
                   expVal, oFirOut, pulseCount);
        end
        // Fixed latency of 15 cycles from the accepted strobe
        assert (cycleCount == dueCycle)
        else
        begin
          errCount++;
          $display("Valid pulse %0d arrived at cycle %0d instead of cycle %0d",
                   pulseCount, cycleCount, dueCycle);
        end
      end
      lastOut = oFirOut;
    end
  end

  // ====================
  // Stimulus tasks
  // ====================
  task automatic loadBanks(input int firstBank, input int lastBank);
    int b;
    int k;
    iCoeffUpdate = 1'b1;
    for (b = firstBank; b <= lastBank; b++)
    begin
      for (k = 0; k < TapsPerBank; k++)
      begin
        iCoeffWrEn             = 1'b1;
        iCoeffAddr.field.bank  = BankSelW'(b);
        iCoeffAddr.field.index = IdxW'(k);
        iCoeffData             = coefModel[b*TapsPerBank + k];
        @(posedge iClk);
        #1;
      end
    end
    iCoeffWrEn = 1'b0;
    // Last write lands one edge after it is taken
    @(posedge iClk);
    #1;
    iCoeffUpdate = 1'b0;
    @(posedge iClk);
    #1;
  endtask

  task automatic driveStrobe(input sampleT s);
    iSampleEn = 1'b1;
    iSample   = s;
    @(posedge iClk);
    #1;
    iSampleEn = 1'b0;
  endtask

  task automatic expectOutput(input laneT value);
    expQ.push_back(value);
    // Strobe is taken on the next edge, output follows 15 edges later
    dueQ.push_back(cycleCount + 16);
    expectedPulses++;
  endtask

  task automatic waitForPulses();
    while (expQ.size() > 0)
    begin
      @(posedge iClk);
      #1;
    end
  endtask

  task automatic strobeAndCheck(input sampleT s, input laneT expected);
    expectOutput(expected);
    driveStrobe(s);
    waitForPulses();
  endtask

  task automatic finishTest(input int num, input string name);
    int failed;
    failed = errCount - testStartErrors;
    if (failed == 0)
      $display("Test %0d %s: ok", num, name);
    else
      $display("Test %0d %s: %0d errors", num, name, failed);
    testStartErrors = errCount;
  endtask

  // ====================
  // Test sequence
  // ====================
  initial
  begin
    int     n;
    int     pulsesBefore;
    sampleT s;

    iCoeffUpdate = 1'b0;
    iCoeffWrEn   = 1'b0;
    iCoeffAddr   = '0;
    iCoeffData   = '0;
    iSampleEn    = 1'b0;
    iSample      = '0;
    arstN        = 1'b0;
    clearHistory();
    repeat (ResetCycles) @(posedge iClk);
    #1;
    arstN = 1'b1;

    // Quiet outputs before any strobe
    repeat (12)
    begin
      @(negedge iClk);
      checkCount++;
      assert (!oFirValid)
      else
      begin
        errCount++;
        $display("oFirValid went high before any strobe");
      end
      assert (oFirOut == '0)
      else
      begin
        errCount++;
        $display("MISMATCH oFirOut: expected %h, got %h", 16'h0000, oFirOut);
      end
    end
    @(posedge iClk);
    #1;
    finishTest(1, "reset state");

    // Impulse walks out the coefficients in tap order
    for (n = 0; n < TotalTaps; n++)
      coefModel[n] = coeffT'(1187 * n - 23111);
    loadBanks(0, NumBanks - 1);
    for (n = 0; n < TotalTaps; n++)
    begin
      s = (n == 0) ? sampleT'(1) : sampleT'(0);
      shiftHistory(s);
      strobeAndCheck(s, coefModel[n]);
    end
    finishTest(2, "impulse response");

    for (n = 0; n < TotalTaps; n++)
      coefModel[n] = coeffT'(randomBits(16));
    loadBanks(0, NumBanks - 1);
    for (n = 0; n < RandomLen; n++)
    begin
      s = sampleT'(randomBits(3));
      shiftHistory(s);
      strobeAndCheck(s, firExpected());
    end
    finishTest(3, "random samples");

    // Full-scale coefficients drive every clamp to its limit
    for (n = 0; n < TotalTaps; n++)
      coefModel[n] = 16'sh7FFF;
    loadBanks(0, NumBanks - 1);
    for (n = 0; n < SatLen; n++)
    begin
      s = (n < TotalTaps) ? sampleT'(-4) : sampleT'(3);
      shiftHistory(s);
      strobeAndCheck(s, firExpected());
      if (n == TotalTaps - 1 || n == SatLen - 1)
      begin
        checkCount++;
        expVal = (n < TotalTaps) ? 16'sh8000 : 16'sh7FFF;
        assert (lastOut == expVal)
        else
        begin
          errCount++;
          $display("MISMATCH oFirOut: expected %h, got %h at full window", expVal, lastOut);
        end
      end
    end
    finishTest(4, "saturation");

    // Update raised mid-run abandons it; strobe under update is dropped
    pulsesBefore = pulseCount;
    shiftHistory(sampleT'(2));
    driveStrobe(sampleT'(2));
    repeat (3) @(posedge iClk);
    #1;
    iCoeffUpdate = 1'b1;
    @(posedge iClk);
    #1;
    driveStrobe(sampleT'(-3));
    iCoeffUpdate = 1'b0;
    repeat (24) @(posedge iClk);
    #1;
    checkCount++;
    assert (pulseCount == pulsesBefore)
    else
    begin
      errCount++;
      $display("Abandoned run still produced a valid pulse");
    end
    // Strobes at 5 and 15 cycles are early, the one at 16 is taken
    shiftHistory(sampleT'(1));
    expectOutput(firExpected());
    driveStrobe(sampleT'(1));
    repeat (4) @(posedge iClk);
    #1;
    driveStrobe(sampleT'(-2));
    repeat (9) @(posedge iClk);
    #1;
    driveStrobe(sampleT'(3));
    shiftHistory(sampleT'(-1));
    expectOutput(firExpected());
    driveStrobe(sampleT'(-1));
    waitForPulses();
    finishTest(5, "update and early strobes");

    // Moderate coefficients so one bank's change shows in the sum
    for (n = 0; n < TotalTaps; n++)
      coefModel[n] = coeffT'(int'(randomBits(12)) - 2048);
    loadBanks(0, NumBanks - 1);
    for (n = 0; n < RewriteLen; n++)
    begin
      if (n == RewriteLen / 2)
      begin
        for (int k = 0; k < TapsPerBank; k++)
          coefModel[2*TapsPerBank + k] = coeffT'(int'(randomBits(12)) - 2048);
        loadBanks(2, 2);
      end
      s = sampleT'(randomBits(3));
      shiftHistory(s);
      strobeAndCheck(s, firExpected());
    end
    finishTest(6, "bank rewrite");

    checkCount++;
    assert (pulseCount == expectedPulses)
    else
    begin
      errCount++;
      $display("Saw %0d valid pulses for %0d expected outputs", pulseCount, expectedPulses);
    end
    $display("Checks: %0d, errors: %0d, pulses: %0d of %0d expected",
             checkCount, errCount, pulseCount, expectedPulses);
    if (errCount == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire
